/* Bender.yml */
package:
  name: w_buffer

sources:
  - w_buffer_pkg.sv
  - w_stream_fifo.sv
  - w_burst_ctrl.sv
  - w_buffer_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_w_buffer.sv

/* all.f */
+incdir+.
w_buffer_pkg.sv
w_stream_fifo.sv
w_burst_ctrl.sv
w_buffer_top.sv
tb_w_buffer.sv

/* tb_w_buffer_ref.svh */
// Reference model for the expected master beats and B-drop records, and the value compare task
`ifndef TB_W_BUFFER_REF_SVH
`define TB_W_BUFFER_REF_SVH

  // Accepted bursts reach the master in order and carry the master select of their decision
  // Each dropped burst leaves exactly one drop record once its last beat is consumed
  function automatic void build_expected();
    int        d;
    beat_rec_t brec;
    drop_rec_t drec;
    d = 0;
    exp_beats.delete();
    exp_drops.delete();
    foreach (beat_q[i]) begin
      if (dec_q[d].action == W_ACCEPT) begin
        brec.master = dec_q[d].master;
        brec.beat   = beat_q[i];
        exp_beats.push_back(brec);
      end
      if (beat_q[i].last) begin
        if (dec_q[d].action == W_DROP) begin
          drec.id       = dec_q[d].id;
          drec.prefetch = dec_q[d].prefetch;
          drec.hit      = dec_q[d].hit;
          exp_drops.push_back(drec);
        end
        d++;
      end
    end
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

`endif

/* tb_w_buffer.sv */
// Testbench for the W buffer with drivers, B-sender model, monitor, timeout and scoreboard
`timescale 1ns/100ps

module tb_w_buffer;

  import w_buffer_pkg::*;

  localparam int BEAT_DEPTH     = 4;
  localparam int DECISION_DEPTH = 8;
  localparam int MAX_LEN        = 8;
  localparam int N_ACCEPT       = 8;
  localparam int N_DROP         = 8;
  localparam int N_MIX          = 24;
  localparam int N_FULL         = 12;
  // 40 cycles for every beat of every test at the longest burst length
  localparam int TIMEOUT_CYCLES = 40 * MAX_LEN * (N_ACCEPT + N_DROP + N_MIX + N_FULL) + 500;

  typedef struct packed {
    logic    master;
    w_beat_t beat;
  } beat_rec_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0] id;
    logic                    prefetch;
    logic                    hit;
  } drop_rec_t;

  logic                        axi4_aclk;
  logic                        axi4_arstn;
  logic                        l1_accept_i;
  logic                        l1_drop_i;
  logic                        l1_master_i;
  logic [AXI_ID_WIDTH-1:0]     l1_id_i;
  logic                        l1_prefetch_i;
  logic                        l1_hit_i;
  logic                        l1_done_o;
  logic                        input_stall_o;
  logic [AXI_DATA_WIDTH-1:0]   s_axi4_wdata_i;
  logic [AXI_DATA_WIDTH/8-1:0] s_axi4_wstrb_i;
  logic [AXI_USER_WIDTH-1:0]   s_axi4_wuser_i;
  logic                        s_axi4_wlast_i;
  logic                        s_axi4_wvalid_i;
  logic                        s_axi4_wready_o;
  logic [AXI_DATA_WIDTH-1:0]   m_axi4_wdata_o;
  logic [AXI_DATA_WIDTH/8-1:0] m_axi4_wstrb_o;
  logic [AXI_USER_WIDTH-1:0]   m_axi4_wuser_o;
  logic                        m_axi4_wlast_o;
  logic                        m_axi4_wvalid_o;
  logic                        m_axi4_wready_i;
  logic                        master_select_o;
  logic                        b_drop_o;
  logic                        b_done_i;
  logic [AXI_ID_WIDTH-1:0]     id_o;
  logic                        prefetch_o;
  logic                        hit_o;

  integer seed = 88;
  int     err_count = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     cycle_cnt = 0;
  int     b_wait = 0;
  int     wvalid_cycles;
  int     done_before_stall;
  bit     stall_seen;
  bit     bp_en;
  bit     gaps_en;

  l1_decision_t dec_q[$];
  w_beat_t      beat_q[$];
  beat_rec_t    exp_beats[$];
  beat_rec_t    got_beats[$];
  drop_rec_t    exp_drops[$];
  drop_rec_t    got_drops[$];

  `include "tb_w_buffer_ref.svh"

  w_buffer_top #(
    .BEAT_DEPTH     (BEAT_DEPTH),
    .DECISION_DEPTH (DECISION_DEPTH)
  ) u_w_buffer_top (.*);

  initial begin
    axi4_aclk = 1'b0;
    forever #2 axi4_aclk = ~axi4_aclk;
  end

  always @(posedge axi4_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Master back-pressure and B-sender model with a 0 to 5 cycle answer delay
  always @(negedge axi4_aclk) begin
    m_axi4_wready_i = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
    if (b_done_i || !b_drop_o) begin
      b_done_i = 1'b0;
      b_wait   = $unsigned($random(seed)) % 6;
    end else if (b_wait == 0) begin
      b_done_i = 1'b1;
    end else begin
      b_wait = b_wait - 1;
    end
  end

  // Sample just before the rising edge, where every handshake signal is settled
  always @(negedge axi4_aclk) begin : monitor
    beat_rec_t brec;
    drop_rec_t drec;
    #1;
    if (axi4_arstn && m_axi4_wvalid_o) begin
      wvalid_cycles++;
    end
    if (axi4_arstn && m_axi4_wvalid_o && m_axi4_wready_i) begin
      brec = '{master: master_select_o,
               beat: '{data: m_axi4_wdata_o, strb: m_axi4_wstrb_o,
                       user: m_axi4_wuser_o, last: m_axi4_wlast_o}};
      got_beats.push_back(brec);
    end
    if (axi4_arstn && b_drop_o && b_done_i) begin
      drec = '{id: id_o, prefetch: prefetch_o, hit: hit_o};
      got_drops.push_back(drec);
    end
  end

  // Mode 0 accepts every burst, mode 1 drops every burst, mode 2 mixes both
  task automatic gen_bursts(input int count, input int mode);
    l1_decision_t dec;
    w_beat_t      beat;
    int           len;
    dec_q.delete();
    beat_q.delete();
    for (int i = 0; i < count; i++) begin
      len          = ($random(seed) & 7) + 1;
      dec.master   = $random(seed);
      dec.id       = $random(seed);
      dec.prefetch = $random(seed);
      dec.hit      = $random(seed);
      case (mode)
        0:       dec.action = W_ACCEPT;
        1:       dec.action = W_DROP;
        default: dec.action = ($random(seed) & 1) ? W_DROP : W_ACCEPT;
      endcase
      dec_q.push_back(dec);
      for (int k = 0; k < len; k++) begin
        beat.data = $random(seed);
        beat.strb = $random(seed);
        beat.user = $random(seed);
        beat.last = (k == len - 1);
        beat_q.push_back(beat);
      end
    end
  endtask

  task automatic drive_decisions();
    int i;
    i = 0;
    while (i < dec_q.size()) begin
      @(negedge axi4_aclk);
      l1_accept_i   = (dec_q[i].action == W_ACCEPT);
      l1_drop_i     = (dec_q[i].action == W_DROP);
      l1_master_i   = dec_q[i].master;
      l1_id_i       = dec_q[i].id;
      l1_prefetch_i = dec_q[i].prefetch;
      l1_hit_i      = dec_q[i].hit;
      #1;
      if (input_stall_o) begin
        stall_seen = 1'b1;
      end
      if (l1_done_o) begin
        done_before_stall += stall_seen ? 0 : 1;
        i++;
      end
    end
    @(negedge axi4_aclk);
    l1_accept_i = 1'b0;
    l1_drop_i   = 1'b0;
  endtask

  task automatic drive_beats();
    int i;
    bit hold;
    i    = 0;
    hold = 1'b0;
    while (i < beat_q.size()) begin
      @(negedge axi4_aclk);
      // A gap is only inserted while no beat is waiting for ready
      if (!hold && gaps_en && (($random(seed) & 3) == 0)) begin
        s_axi4_wvalid_i = 1'b0;
      end else begin
        s_axi4_wdata_i  = beat_q[i].data;
        s_axi4_wstrb_i  = beat_q[i].strb;
        s_axi4_wuser_i  = beat_q[i].user;
        s_axi4_wlast_i  = beat_q[i].last;
        s_axi4_wvalid_i = 1'b1;
        #1;
        hold = !s_axi4_wready_o;
        i    = s_axi4_wready_o ? i + 1 : i;
      end
    end
    @(negedge axi4_aclk);
    s_axi4_wvalid_i = 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d mismatches", num, name, err_count - errs_before);
    end
  endtask

  task automatic run_test(input int num, input string name, input int count, input int mode,
                          input bit bp, input bit gaps, input bit wait_stall);
    int errs_before;
    errs_before = err_count;
    gen_bursts(count, mode);
    build_expected();
    got_beats.delete();
    got_drops.delete();
    wvalid_cycles     = 0;
    done_before_stall = 0;
    stall_seen        = 1'b0;
    bp_en             = bp;
    gaps_en           = gaps;
    fork
      drive_decisions();
      begin
        while (wait_stall && !stall_seen) begin
          @(negedge axi4_aclk);
        end
        drive_beats();
      end
    join
    while (got_beats.size() < exp_beats.size() || got_drops.size() < exp_drops.size()) begin
      @(negedge axi4_aclk);
    end
    // Idle time so that any extra beat or drop would still be caught
    repeat (10) @(negedge axi4_aclk);
    bp_en = 1'b0;
    check_equal(got_beats.size(), exp_beats.size(), "master beat count");
    check_equal(got_drops.size(), exp_drops.size(), "drop record count");
    for (int i = 0; i < got_beats.size() && i < exp_beats.size(); i++) begin
      check_equal(got_beats[i], exp_beats[i], $sformatf("master beat %0d", i));
    end
    for (int i = 0; i < got_drops.size() && i < exp_drops.size(); i++) begin
      check_equal(got_drops[i], exp_drops[i], $sformatf("drop record %0d", i));
    end
    if (mode == 1) begin
      check_equal(wvalid_cycles, 0, "cycles with m_axi4_wvalid_o high");
    end
    if (wait_stall) begin
      check_equal(done_before_stall, DECISION_DEPTH, "decisions done before stall");
    end
    report_test(num, name, errs_before);
  endtask

  initial begin : main_seq
    int errs_before;
    axi4_arstn      = 1'b0;
    l1_accept_i     = 1'b0;
    l1_drop_i       = 1'b0;
    l1_master_i     = 1'b0;
    l1_id_i         = '0;
    l1_prefetch_i   = 1'b0;
    l1_hit_i        = 1'b0;
    s_axi4_wdata_i  = '0;
    s_axi4_wstrb_i  = '0;
    s_axi4_wuser_i  = '0;
    s_axi4_wlast_i  = 1'b0;
    s_axi4_wvalid_i = 1'b0;
    m_axi4_wready_i = 1'b1;
    b_done_i        = 1'b0;
    repeat (16) @(posedge axi4_aclk);
    @(negedge axi4_aclk);
    axi4_arstn = 1'b1;
    @(negedge axi4_aclk);
    #1;
    errs_before = err_count;
    check_equal(m_axi4_wvalid_o, 1'b0, "m_axi4_wvalid_o after reset");
    check_equal(b_drop_o, 1'b0, "b_drop_o after reset");
    check_equal(l1_done_o, 1'b0, "l1_done_o after reset");
    check_equal(input_stall_o, 1'b0, "input_stall_o after reset");
    check_equal(s_axi4_wready_o, 1'b1, "s_axi4_wready_o after reset");
    report_test(1, "reset state", errs_before);
    run_test(2, "accepted bursts", N_ACCEPT, 0, 1'b0, 1'b0, 1'b0);
    run_test(3, "dropped bursts", N_DROP, 1, 1'b0, 1'b0, 1'b0);
    run_test(4, "mixed traffic", N_MIX, 2, 1'b1, 1'b1, 1'b0);
    run_test(5, "decision FIFO full", N_FULL, 2, 1'b0, 1'b0, 1'b1);
    $display("Summary: %0d tests ok, %0d tests with mismatches, %0d mismatches in total",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* w_buffer_pkg.sv */
// Channel widths, W beat and L1 decision structs, burst action and controller state enums
package w_buffer_pkg;

  // AXI channel widths shared by the beat and decision structs
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_ID_WIDTH   = 4;
  localparam int AXI_USER_WIDTH = 4;

  // One W beat as it sits in the input FIFO
  // Strobe carries one bit per data byte
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0]   data;
    logic [AXI_DATA_WIDTH/8-1:0] strb;
    logic [AXI_USER_WIDTH-1:0]   user;
    logic                        last;
  } w_beat_t;

  // Fate of one write burst as decided by the L1 TLB
  typedef enum logic {
    W_ACCEPT = 1'b0,
    W_DROP   = 1'b1
  } w_action_e;

  // One translation result, queued until its burst has drained
  typedef struct packed {
    w_action_e               action;
    logic                    master;
    logic [AXI_ID_WIDTH-1:0] id;
    logic                    prefetch;
    logic                    hit;
  } l1_decision_t;

  // Output controller state
  // BURST_PASS forwards or swallows beats, DROP_NOTIFY waits on the B sender
  typedef enum logic {
    BURST_PASS  = 1'b0,
    DROP_NOTIFY = 1'b1
  } burst_state_e;

endpackage

/* w_buffer_top.sv */
// Top level of the W buffer with beat FIFO, decision FIFO and burst controller
`timescale 1ns/100ps

module w_buffer_top #(
  parameter int BEAT_DEPTH     = 4,
  parameter int DECISION_DEPTH = 8
) (
  input  logic                                      axi4_aclk,
  input  logic                                      axi4_arstn,

  // L1 TLB decisions
  input  logic                                      l1_accept_i,
  input  logic                                      l1_drop_i,
  input  logic                                      l1_master_i,
  input  logic [w_buffer_pkg::AXI_ID_WIDTH-1:0]     l1_id_i,
  input  logic                                      l1_prefetch_i,
  input  logic                                      l1_hit_i,
  output logic                                      l1_done_o,
  output logic                                      input_stall_o,

  // Slave W channel
  input  logic [w_buffer_pkg::AXI_DATA_WIDTH-1:0]   s_axi4_wdata_i,
  input  logic [w_buffer_pkg::AXI_DATA_WIDTH/8-1:0] s_axi4_wstrb_i,
  input  logic [w_buffer_pkg::AXI_USER_WIDTH-1:0]   s_axi4_wuser_i,
  input  logic                                      s_axi4_wlast_i,
  input  logic                                      s_axi4_wvalid_i,
  output logic                                      s_axi4_wready_o,

  // Master W channel
  output logic [w_buffer_pkg::AXI_DATA_WIDTH-1:0]   m_axi4_wdata_o,
  output logic [w_buffer_pkg::AXI_DATA_WIDTH/8-1:0] m_axi4_wstrb_o,
  output logic [w_buffer_pkg::AXI_USER_WIDTH-1:0]   m_axi4_wuser_o,
  output logic                                      m_axi4_wlast_o,
  output logic                                      m_axi4_wvalid_o,
  input  logic                                      m_axi4_wready_i,

  // Master routing and B sender
  output logic                                      master_select_o,
  output logic                                      b_drop_o,
  input  logic                                      b_done_i,
  output logic [w_buffer_pkg::AXI_ID_WIDTH-1:0]     id_o,
  output logic                                      prefetch_o,
  output logic                                      hit_o
);

  import w_buffer_pkg::*;

  w_beat_t      s_beat;
  w_beat_t      fifo_beat;
  logic         fifo_beat_valid;
  logic         fifo_beat_ready;
  w_beat_t      m_beat;

  l1_decision_t l1_decision;
  l1_decision_t head_decision;
  logic         l1_req;
  logic         dec_push_ready;
  logic         head_valid;
  logic         head_pop;

  assign s_beat = '{data: s_axi4_wdata_i, strb: s_axi4_wstrb_i,
                    user: s_axi4_wuser_i, last: s_axi4_wlast_i};

  // Accept has priority if both strobes are seen
  assign l1_req      = l1_accept_i | l1_drop_i;
  assign l1_decision = '{action:   (l1_accept_i ? W_ACCEPT : W_DROP),
                         master:   l1_master_i,
                         id:       l1_id_i,
                         prefetch: l1_prefetch_i,
                         hit:      l1_hit_i};

  assign l1_done_o     = l1_req & dec_push_ready;
  assign input_stall_o = ~dec_push_ready;

  w_stream_fifo #(
    .DEPTH  (BEAT_DEPTH),
    .elem_t (w_beat_t)
  ) u_beat_fifo (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .push_data_i  (s_beat),
    .push_valid_i (s_axi4_wvalid_i),
    .push_ready_o (s_axi4_wready_o),
    .pop_data_o   (fifo_beat),
    .pop_valid_o  (fifo_beat_valid),
    .pop_ready_i  (fifo_beat_ready)
  );

  w_stream_fifo #(
    .DEPTH  (DECISION_DEPTH),
    .elem_t (l1_decision_t)
  ) u_decision_fifo (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .push_data_i  (l1_decision),
    .push_valid_i (l1_req),
    .push_ready_o (dec_push_ready),
    .pop_data_o   (head_decision),
    .pop_valid_o  (head_valid),
    .pop_ready_i  (head_pop)
  );

  w_burst_ctrl u_burst_ctrl (
    .axi4_aclk        (axi4_aclk),
    .axi4_arstn       (axi4_arstn),
    .beat_i           (fifo_beat),
    .beat_valid_i     (fifo_beat_valid),
    .beat_ready_o     (fifo_beat_ready),
    .decision_i       (head_decision),
    .decision_valid_i (head_valid),
    .decision_pop_o   (head_pop),
    .m_beat_o         (m_beat),
    .m_valid_o        (m_axi4_wvalid_o),
    .m_ready_i        (m_axi4_wready_i),
    .master_select_o  (master_select_o),
    .b_drop_o         (b_drop_o),
    .b_done_i         (b_done_i),
    .id_o             (id_o),
    .prefetch_o       (prefetch_o),
    .hit_o            (hit_o)
  );

  assign m_axi4_wdata_o = m_beat.data;
  assign m_axi4_wstrb_o = m_beat.strb;
  assign m_axi4_wuser_o = m_beat.user;
  assign m_axi4_wlast_o = m_beat.last;

endmodule

/* w_burst_ctrl.sv */
// Output controller that forwards or discards W bursts and runs the B-sender drop handshake
`timescale 1ns/100ps

module w_burst_ctrl (
  input  logic                                    axi4_aclk,
  input  logic                                    axi4_arstn,

  // Beats from the input FIFO
  input  w_buffer_pkg::w_beat_t                   beat_i,
  input  logic                                    beat_valid_i,
  output logic                                    beat_ready_o,

  // Head of the decision FIFO
  input  w_buffer_pkg::l1_decision_t              decision_i,
  input  logic                                    decision_valid_i,
  output logic                                    decision_pop_o,

  // Master W channel
  output w_buffer_pkg::w_beat_t                   m_beat_o,
  output logic                                    m_valid_o,
  input  logic                                    m_ready_i,
  output logic                                    master_select_o,

  // B sender
  output logic                                    b_drop_o,
  input  logic                                    b_done_i,
  output logic [w_buffer_pkg::AXI_ID_WIDTH-1:0]   id_o,
  output logic                                    prefetch_o,
  output logic                                    hit_o
);

  import w_buffer_pkg::*;

  burst_state_e state_q;
  burst_state_e state_d;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q <= BURST_PASS;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    m_beat_o       = '0;
    m_valid_o      = 1'b0;
    beat_ready_o   = 1'b0;
    decision_pop_o = 1'b0;

    // Beats only move once their burst has a decision
    if (decision_valid_i) begin
      if (decision_i.action == W_ACCEPT) begin
        // Pass the beat straight through to the master
        if (beat_valid_i) begin
          m_beat_o = beat_i;
        end
        m_valid_o      = beat_valid_i;
        beat_ready_o   = m_ready_i;
        decision_pop_o = beat_valid_i & m_ready_i & beat_i.last;
      end else if (state_q == BURST_PASS) begin
        // Swallow the burst, then tell the B sender
        beat_ready_o = 1'b1;
        if (beat_valid_i && beat_i.last) begin
          state_d = DROP_NOTIFY;
        end
      end else begin
        // Hold the drop request until the B sender is done
        if (b_done_i) begin
          decision_pop_o = 1'b1;
          state_d        = BURST_PASS;
        end
      end
    end
  end

  assign b_drop_o = (state_q == DROP_NOTIFY);

  // Routing and response fields follow the head decision
  assign master_select_o = decision_i.master;
  assign id_o            = decision_i.id;
  assign prefetch_o      = decision_i.prefetch;
  assign hit_o           = decision_i.hit;

endmodule

/* w_stream_fifo.sv */
// Register-based valid/ready FIFO with configurable depth and element type
`timescale 1ns/100ps

module w_stream_fifo #(
  parameter int  DEPTH  = 4,
  parameter type elem_t = logic [7:0]
) (
  input  logic  axi4_aclk,
  input  logic  axi4_arstn,

  // Write side
  input  elem_t push_data_i,
  input  logic  push_valid_i,
  output logic  push_ready_o,

  // Read side, head element straight from the register array
  output elem_t pop_data_o,
  output logic  pop_valid_o,
  input  logic  pop_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  elem_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_fire;
  logic             pop_fire;

  // Advance a pointer, wrapping at the last slot
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  // Pointers and occupancy
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_fire) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge axi4_aclk) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule
